//--- logic/csr_rfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "prv_defines.svh"

module csr_rfile (
  input  logic                              CLK,
  input  logic                              nRST,
  // Pipeline CSR port
  input  rv32i_types_pkg::csr_addr_t        csr_addr,
  input  logic                              swap,
  input  logic                              set,
  input  logic                              clr,
  input  rv32i_types_pkg::word_t            wdata,
  output rv32i_types_pkg::word_t            rdata,
  output logic                              invalid_csr,
  // Update requests from the trap controller
  input  logic                              mcause_rup,
  input  logic                              mepc_rup,
  input  logic                              mbadaddr_rup,
  input  logic                              mstatus_rup,
  input  machine_mode_types_pkg::mcause_t   mcause_next,
  input  rv32i_types_pkg::word_t            mepc_next,
  input  rv32i_types_pkg::word_t            mbadaddr_next,
  input  logic                              ie_next,
  input  machine_mode_types_pkg::mip_t      mip_next,
  // State seen by the trap controller
  output rv32i_types_pkg::word_t            mtvec,
  output rv32i_types_pkg::word_t            mepc,
  output machine_mode_types_pkg::mie_t      mie,
  output machine_mode_types_pkg::mip_t      mip,
  output logic                              ie
);

  machine_mode_types_pkg::mcpuid_t   mcpuid;
  machine_mode_types_pkg::mstatus_t  mstatus;
  machine_mode_types_pkg::mcause_t   mcause;
  rv32i_types_pkg::word_t            mbadaddr;
  rv32i_types_pkg::word_t            mscratch;
  rv32i_types_pkg::word_t            mtohost;
  rv32i_types_pkg::word_t            mfromhost;
  logic                              msie;
  logic                              mtie;
  logic                              csr_op;
  logic                              valid_addr;
  logic                              wr_mstatus;
  logic                              wr_mie;
  logic                              wr_mscratch;
  logic                              wr_mtohost;
  machine_mode_types_pkg::csr_word_u wr_val;

  // RV32I, no other extensions
  assign mcpuid.base       = machine_mode_types_pkg::BASE_RV32;
  assign mcpuid.zero       = '0;
  assign mcpuid.extensions = machine_mode_types_pkg::MCPUID_EXT_I;

  // Trap vector is hardwired
  assign mtvec = `MTVEC_ADDR;

  // Host input never changes from its reset value
  assign mfromhost = '0;

  // Machine mode only, bare addressing, no FPU
  always_comb begin
    mstatus      = '0;
    mstatus.ie   = ie;
    mstatus.prv  = machine_mode_types_pkg::M_MODE;
    mstatus.prv1 = machine_mode_types_pkg::M_MODE;
    mstatus.prv2 = machine_mode_types_pkg::M_MODE;
    mstatus.prv3 = machine_mode_types_pkg::M_MODE;
    mstatus.vm   = machine_mode_types_pkg::VM_MBARE;
    mstatus.xs   = machine_mode_types_pkg::ST_OFF;
    mstatus.fs   = machine_mode_types_pkg::ST_OFF;
  end

  // Two live enable bits
  always_comb begin
    mie      = '0;
    mie.msie = msie;
    mie.mtie = mtie;
  end

  // Pending bits come straight from the controller's registers
  always_comb begin
    mip      = '0;
    mip.msip = mip_next.msip;
    mip.mtip = mip_next.mtip;
  end

  // Any of the three strobes is a CSR access
  assign csr_op      = swap | set | clr;
  assign invalid_csr = csr_op & ~valid_addr;

  // Read-modify-write value
  always_comb begin
    if (swap) begin
      wr_val.raw = wdata;
    end else if (clr) begin
      wr_val.raw = rdata & ~wdata;
    end else begin
      wr_val.raw = rdata | wdata;
    end
  end

  // Pipeline-writable registers
  assign wr_mstatus  = csr_op & (csr_addr == machine_mode_types_pkg::CSR_MSTATUS);
  assign wr_mie      = csr_op & (csr_addr == machine_mode_types_pkg::CSR_MIE);
  assign wr_mscratch = csr_op & (csr_addr == machine_mode_types_pkg::CSR_MSCRATCH);
  assign wr_mtohost  = csr_op & (csr_addr == machine_mode_types_pkg::CSR_MTOHOST);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ie       <= 1'b1;
      msie     <= 1'b0;
      mtie     <= 1'b0;
      mcause   <= '0;
      mepc     <= '0;
      mbadaddr <= '0;
      mscratch <= '0;
      mtohost  <= '0;
    end else begin
      // Trap entry and mret override a pipeline mstatus write
      if (mstatus_rup) begin
        ie <= ie_next;
      end else if (wr_mstatus) begin
        ie <= wr_val.mstatus.ie;
      end
      if (wr_mie) begin
        msie <= wr_val.mie.msie;
        mtie <= wr_val.mie.mtie;
      end
      if (wr_mscratch) begin
        mscratch <= wr_val.raw;
      end
      if (wr_mtohost) begin
        mtohost <= wr_val.raw;
      end
      // Controller-only registers
      if (mcause_rup) begin
        mcause <= mcause_next;
      end
      if (mepc_rup) begin
        mepc <= mepc_next;
      end
      if (mbadaddr_rup) begin
        mbadaddr <= mbadaddr_next;
      end
    end
  end

  // Read mux and address check
  always_comb begin
    valid_addr = 1'b1;
    rdata      = '0;
    case (csr_addr)
      machine_mode_types_pkg::CSR_MCPUID:    rdata = mcpuid;
      machine_mode_types_pkg::CSR_MIMPID:    rdata = `MIMPID;
      machine_mode_types_pkg::CSR_MHARTID:   rdata = `MHARTID;
      machine_mode_types_pkg::CSR_MSTATUS:   rdata = mstatus;
      machine_mode_types_pkg::CSR_MTVEC:     rdata = mtvec;
      machine_mode_types_pkg::CSR_MIE:       rdata = mie;
      machine_mode_types_pkg::CSR_MSCRATCH:  rdata = mscratch;
      machine_mode_types_pkg::CSR_MEPC:      rdata = mepc;
      machine_mode_types_pkg::CSR_MCAUSE:    rdata = mcause;
      machine_mode_types_pkg::CSR_MBADADDR:  rdata = mbadaddr;
      machine_mode_types_pkg::CSR_MIP:       rdata = mip;
      machine_mode_types_pkg::CSR_MTOHOST:   rdata = mtohost;
      machine_mode_types_pkg::CSR_MFROMHOST: rdata = mfromhost;
      // No delegation, protection, counters or timers
      machine_mode_types_pkg::CSR_MTDELEG,
      machine_mode_types_pkg::CSR_MBASE,
      machine_mode_types_pkg::CSR_MBOUND,
      machine_mode_types_pkg::CSR_MIBASE,
      machine_mode_types_pkg::CSR_MIBOUND,
      machine_mode_types_pkg::CSR_MDBASE,
      machine_mode_types_pkg::CSR_MDBOUND,
      machine_mode_types_pkg::CSR_MDELTA,
      machine_mode_types_pkg::CSR_MDELTAH,
      machine_mode_types_pkg::CSR_MTIMECMP,
      machine_mode_types_pkg::CSR_MTIME,
      machine_mode_types_pkg::CSR_MTIMEH:    rdata = '0;
      default: begin
        valid_addr = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/machine_mode_types_pkg.sv
`default_nettype none

package machine_mode_types_pkg;

  // Privilege levels held in the mstatus stack
  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    S_MODE = 2'b01,
    H_MODE = 2'b10,
    M_MODE = 2'b11
  } prv_lvl_e;

  // Translation modes
  // Only bare is implemented
  typedef enum logic [4:0] {
    VM_MBARE = 5'd0,
    VM_MBB   = 5'd1,
    VM_MBBID = 5'd2,
    VM_SV32  = 5'd8
  } vm_e;

  // Context state, shared by the fs and xs fields
  typedef enum logic [1:0] {
    ST_OFF     = 2'b00,
    ST_INITIAL = 2'b01,
    ST_CLEAN   = 2'b10,
    ST_DIRTY   = 2'b11
  } ext_state_e;

  // mstatus, privileged spec 1.7
  typedef struct packed {
    logic       sd;
    logic [8:0] zero;
    vm_e        vm;
    logic       mprv;
    ext_state_e xs;
    ext_state_e fs;
    prv_lvl_e   prv3;
    logic       ie3;
    prv_lvl_e   prv2;
    logic       ie2;
    prv_lvl_e   prv1;
    logic       ie1;
    prv_lvl_e   prv;
    logic       ie;
  } mstatus_t;

  // Interrupt enables
  // Only the machine software and timer bits are live
  typedef struct packed {
    logic [23:0] zero_hi;
    logic        mtie;
    logic [2:0]  zero_t;
    logic        msie;
    logic [2:0]  zero_s;
  } mie_t;

  // Interrupt pending, same bit positions as mie
  typedef struct packed {
    logic [23:0] zero_hi;
    logic        mtip;
    logic [2:0]  zero_t;
    logic        msip;
    logic [2:0]  zero_s;
  } mip_t;

  // Trap cause
  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  // CPU identification
  typedef struct packed {
    logic [1:0]  base;
    logic [3:0]  zero;
    logic [25:0] extensions;
  } mcpuid_t;

  localparam logic [1:0]  BASE_RV32    = 2'b00;
  // Letter I is bit 8 of the extension map
  localparam logic [25:0] MCPUID_EXT_I = 26'h000_0100;

  // Synchronous exception codes
  typedef enum logic [30:0] {
    EX_MAL_INSN     = 31'd0,
    EX_ILLEGAL_INSN = 31'd2,
    EX_BREAKPOINT   = 31'd3,
    EX_MAL_LOAD     = 31'd4,
    EX_MAL_STORE    = 31'd6,
    EX_ENV_CALL_M   = 31'd11
  } ex_code_e;

  // Interrupt codes, used with the interrupt flag set
  typedef enum logic [30:0] {
    INT_SOFT  = 31'd0,
    INT_TIMER = 31'd1
  } int_code_e;

  // Updated CSR write word, decoded per target register
  typedef union packed {
    rv32i_types_pkg::word_t raw;
    mstatus_t               mstatus;
    mie_t                   mie;
  } csr_word_u;

  // Machine information
  localparam rv32i_types_pkg::csr_addr_t CSR_MCPUID    = 12'hF00;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIMPID    = 12'hF01;
  localparam rv32i_types_pkg::csr_addr_t CSR_MHARTID   = 12'hF10;

  // Trap setup
  localparam rv32i_types_pkg::csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTVEC     = 12'h301;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTDELEG   = 12'h302;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIE       = 12'h304;

  // Trap handling
  localparam rv32i_types_pkg::csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam rv32i_types_pkg::csr_addr_t CSR_MEPC      = 12'h341;
  localparam rv32i_types_pkg::csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam rv32i_types_pkg::csr_addr_t CSR_MBADADDR  = 12'h343;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIP       = 12'h344;

  // Protection and translation, read as zero
  localparam rv32i_types_pkg::csr_addr_t CSR_MBASE     = 12'h380;
  localparam rv32i_types_pkg::csr_addr_t CSR_MBOUND    = 12'h381;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIBASE    = 12'h382;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIBOUND   = 12'h383;
  localparam rv32i_types_pkg::csr_addr_t CSR_MDBASE    = 12'h384;
  localparam rv32i_types_pkg::csr_addr_t CSR_MDBOUND   = 12'h385;

  // Counter deltas and timers, read as zero
  localparam rv32i_types_pkg::csr_addr_t CSR_MDELTA    = 12'hB01;
  localparam rv32i_types_pkg::csr_addr_t CSR_MDELTAH   = 12'hB81;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTIMECMP  = 12'h321;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTIME     = 12'h701;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTIMEH    = 12'h741;

  // Host communication
  localparam rv32i_types_pkg::csr_addr_t CSR_MTOHOST   = 12'h780;
  localparam rv32i_types_pkg::csr_addr_t CSR_MFROMHOST = 12'h781;

endpackage

`default_nettype wire

//--- logic/prv_block.sv
`timescale 1ns/1ns
`default_nettype none

module prv_block (
  input  logic                       CLK,
  input  logic                       nRST,
  // CSR access from the pipeline
  input  rv32i_types_pkg::csr_addr_t csr_addr,
  input  logic                       swap,
  input  logic                       set,
  input  logic                       clr,
  input  rv32i_types_pkg::word_t     wdata,
  output rv32i_types_pkg::word_t     rdata,
  output logic                       invalid_csr,
  // Trap requests from the pipeline
  input  logic                       mal_insn,
  input  logic                       illegal_insn,
  input  logic                       breakpoint,
  input  logic                       env_call,
  input  logic                       mal_load,
  input  logic                       mal_store,
  input  logic                       mret,
  input  rv32i_types_pkg::word_t     epc,
  input  rv32i_types_pkg::word_t     badaddr,
  input  logic                       timer_int,
  input  logic                       soft_int,
  output logic                       insert_pc,
  output rv32i_types_pkg::word_t     priv_pc
);

  // Controller to CSR file
  logic                            mcause_rup;
  logic                            mepc_rup;
  logic                            mbadaddr_rup;
  logic                            mstatus_rup;
  machine_mode_types_pkg::mcause_t mcause_next;
  rv32i_types_pkg::word_t          mepc_next;
  rv32i_types_pkg::word_t          mbadaddr_next;
  logic                            ie_next;
  machine_mode_types_pkg::mip_t    mip_next;

  // CSR file to controller
  rv32i_types_pkg::word_t          mtvec;
  rv32i_types_pkg::word_t          mepc;
  machine_mode_types_pkg::mie_t    mie;
  machine_mode_types_pkg::mip_t    mip;
  logic                            ie;

  csr_rfile u_csr_rfile (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_addr      (csr_addr),
    .swap          (swap),
    .set           (set),
    .clr           (clr),
    .wdata         (wdata),
    .rdata         (rdata),
    .invalid_csr   (invalid_csr),
    .mcause_rup    (mcause_rup),
    .mepc_rup      (mepc_rup),
    .mbadaddr_rup  (mbadaddr_rup),
    .mstatus_rup   (mstatus_rup),
    .mcause_next   (mcause_next),
    .mepc_next     (mepc_next),
    .mbadaddr_next (mbadaddr_next),
    .ie_next       (ie_next),
    .mip_next      (mip_next),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .mie           (mie),
    .mip           (mip),
    .ie            (ie)
  );

  prv_control u_prv_control (
    .CLK           (CLK),
    .nRST          (nRST),
    .mal_insn      (mal_insn),
    .illegal_insn  (illegal_insn),
    .breakpoint    (breakpoint),
    .env_call      (env_call),
    .mal_load      (mal_load),
    .mal_store     (mal_store),
    .mret          (mret),
    .epc           (epc),
    .badaddr       (badaddr),
    .timer_int     (timer_int),
    .soft_int      (soft_int),
    .insert_pc     (insert_pc),
    .priv_pc       (priv_pc),
    .invalid_csr   (invalid_csr),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .mie           (mie),
    .mip           (mip),
    .ie            (ie),
    .mcause_rup    (mcause_rup),
    .mcause_next   (mcause_next),
    .mepc_rup      (mepc_rup),
    .mepc_next     (mepc_next),
    .mbadaddr_rup  (mbadaddr_rup),
    .mbadaddr_next (mbadaddr_next),
    .mstatus_rup   (mstatus_rup),
    .ie_next       (ie_next),
    .mip_next      (mip_next)
  );

endmodule

`default_nettype wire

//--- logic/prv_control.sv
`timescale 1ns/1ns
`default_nettype none

module prv_control (
  input  logic                              CLK,
  input  logic                              nRST,
  // Pipeline trap port
  input  logic                              mal_insn,
  input  logic                              illegal_insn,
  input  logic                              breakpoint,
  input  logic                              env_call,
  input  logic                              mal_load,
  input  logic                              mal_store,
  input  logic                              mret,
  input  rv32i_types_pkg::word_t            epc,
  input  rv32i_types_pkg::word_t            badaddr,
  input  logic                              timer_int,
  input  logic                              soft_int,
  output logic                              insert_pc,
  output rv32i_types_pkg::word_t            priv_pc,
  // State from the CSR file
  input  logic                              invalid_csr,
  input  rv32i_types_pkg::word_t            mtvec,
  input  rv32i_types_pkg::word_t            mepc,
  input  machine_mode_types_pkg::mie_t      mie,
  input  machine_mode_types_pkg::mip_t      mip,
  input  logic                              ie,
  // Update requests to the CSR file
  output logic                              mcause_rup,
  output machine_mode_types_pkg::mcause_t   mcause_next,
  output logic                              mepc_rup,
  output rv32i_types_pkg::word_t            mepc_next,
  output logic                              mbadaddr_rup,
  output rv32i_types_pkg::word_t            mbadaddr_next,
  output logic                              mstatus_rup,
  output logic                              ie_next,
  output machine_mode_types_pkg::mip_t      mip_next
);

  logic        msip_q;
  logic        mtip_q;
  logic        illegal;
  logic        exception;
  logic        int_soft;
  logic        int_timer;
  logic        interrupt;
  logic        trap;
  logic        bad_addr_cause;
  logic [30:0] cause_code;

  // Interrupt lines sampled once per cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      msip_q <= 1'b0;
      mtip_q <= 1'b0;
    end else begin
      msip_q <= soft_int;
      mtip_q <= timer_int;
    end
  end

  always_comb begin
    mip_next      = '0;
    mip_next.msip = msip_q;
    mip_next.mtip = mtip_q;
  end

  // Unknown CSR counts as an illegal instruction
  assign illegal   = illegal_insn | invalid_csr;
  assign exception = mal_insn | illegal | breakpoint | env_call | mal_load | mal_store;

  // Interrupts need global and per-source enables
  assign int_soft  = ie & mie.msie & mip.msip;
  assign int_timer = ie & mie.mtie & mip.mtip;
  assign interrupt = ~exception & (int_soft | int_timer);
  assign trap      = exception | interrupt;

  // Cause ranking, exceptions first
  always_comb begin
    cause_code     = '0;
    bad_addr_cause = 1'b0;
    if (mal_insn) begin
      cause_code     = machine_mode_types_pkg::EX_MAL_INSN;
      bad_addr_cause = 1'b1;
    end else if (illegal) begin
      cause_code = machine_mode_types_pkg::EX_ILLEGAL_INSN;
    end else if (breakpoint) begin
      cause_code = machine_mode_types_pkg::EX_BREAKPOINT;
    end else if (env_call) begin
      cause_code = machine_mode_types_pkg::EX_ENV_CALL_M;
    end else if (mal_load) begin
      cause_code     = machine_mode_types_pkg::EX_MAL_LOAD;
      bad_addr_cause = 1'b1;
    end else if (mal_store) begin
      cause_code     = machine_mode_types_pkg::EX_MAL_STORE;
      bad_addr_cause = 1'b1;
    end else if (int_soft) begin
      cause_code = machine_mode_types_pkg::INT_SOFT;
    end else if (int_timer) begin
      cause_code = machine_mode_types_pkg::INT_TIMER;
    end
  end

  // Trap entry records cause and return address
  assign mcause_rup    = trap;
  assign mcause_next   = {interrupt, cause_code};
  assign mepc_rup      = trap;
  assign mepc_next     = epc;
  // Faulting address only for misaligned accesses
  assign mbadaddr_rup  = bad_addr_cause;
  assign mbadaddr_next = badaddr;

  // Trap clears ie, mret sets it, trap wins a tie
  assign mstatus_rup = trap | mret;
  assign ie_next     = ~trap;

  // Redirect to handler or back to mepc
  assign insert_pc = trap | mret;
  assign priv_pc   = trap ? mtvec : mepc;

endmodule

`default_nettype wire

//--- logic/prv_defines.svh
`ifndef PRV_DEFINES_SVH
`define PRV_DEFINES_SVH

// Fixed entry point of every trap
`define MTVEC_ADDR 32'h0000_01C0

// Single hart
`define MHARTID 32'h0000_0000

// No implementation numbering yet
`define MIMPID 32'h0000_0000

`endif

//--- logic/rv32i_types_pkg.sv
`default_nettype none

package rv32i_types_pkg;

  // Architectural word width
  localparam int WORD_W = 32;

  // Width of the CSR field in SYSTEM instructions
  localparam int CSR_ADDR_W = 12;

  // Data word as seen by the register file and CSRs
  typedef logic [WORD_W-1:0] word_t;

  // CSR address from the instruction immediate
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the privileged unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_prv_block -f verilog.f -o sim_prv_block

# The simulator may exit nonzero on failure, so the output decides
sim_out=$(./obj_dir/sim_prv_block 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qF "All tests passed!"; then
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi

//--- testbench/tb_prv_block.sv
`timescale 1ns/1ns
`default_nettype none

`include "prv_defines.svh"

module tb_prv_block;

  localparam int PERIOD          = 100;
  // Roughly 220 cycles of tests plus margin
  localparam int WATCHDOG_CYCLES = 450;
  localparam int OP_READ         = 0;
  localparam int OP_SWAP         = 1;
  localparam int OP_SET          = 2;
  localparam int OP_CLR          = 3;

  logic                       CLK;
  logic                       nRST;
  rv32i_types_pkg::csr_addr_t csr_addr;
  logic                       swap;
  logic                       set;
  logic                       clr;
  rv32i_types_pkg::word_t     wdata;
  rv32i_types_pkg::word_t     rdata;
  logic                       invalid_csr;
  logic                       mal_insn;
  logic                       illegal_insn;
  logic                       breakpoint;
  logic                       env_call;
  logic                       mal_load;
  logic                       mal_store;
  logic                       mret;
  rv32i_types_pkg::word_t     epc;
  rv32i_types_pkg::word_t     badaddr;
  logic                       timer_int;
  logic                       soft_int;
  logic                       insert_pc;
  rv32i_types_pkg::word_t     priv_pc;

  // Scoreboard copy of the stored CSR state
  logic        m_ie;
  logic        m_msie;
  logic        m_mtie;
  logic        m_msip;
  logic        m_mtip;
  logic [31:0] m_mscratch;
  logic [31:0] m_mtohost;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_mbadaddr;

  integer      seed;
  logic [11:0] zero_addrs [13];
  logic [11:0] fixed_addrs [8];

  prv_block uut (
    .CLK          (CLK),
    .nRST         (nRST),
    .csr_addr     (csr_addr),
    .swap         (swap),
    .set          (set),
    .clr          (clr),
    .wdata        (wdata),
    .rdata        (rdata),
    .invalid_csr  (invalid_csr),
    .mal_insn     (mal_insn),
    .illegal_insn (illegal_insn),
    .breakpoint   (breakpoint),
    .env_call     (env_call),
    .mal_load     (mal_load),
    .mal_store    (mal_store),
    .mret         (mret),
    .epc          (epc),
    .badaddr      (badaddr),
    .timer_int    (timer_int),
    .soft_int     (soft_int),
    .insert_pc    (insert_pc),
    .priv_pc      (priv_pc)
  );

  initial begin
    CLK = 1'b0;
    forever #(PERIOD/2) CLK = ~CLK;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    fail_run("Timeout: the tests did not finish within the watchdog limit");
  end

  // A trap without mret always lands on the fixed vector
  trap_vector_check: assert property (@(posedge CLK) disable iff (!nRST)
      (insert_pc && !mret) |-> (priv_pc == `MTVEC_ADDR))
    else fail_run($sformatf("ERROR %0t priv_pc expected %h got %h",
                            $time, `MTVEC_ADDR, priv_pc));

  // Addresses the CSR file answers
  function automatic logic addr_known(input logic [11:0] a);
    case (a)
      12'hF00, 12'hF01, 12'hF10, 12'h300, 12'h301, 12'h302, 12'h304,
      12'h340, 12'h341, 12'h342, 12'h343, 12'h344, 12'h780, 12'h781,
      12'h380, 12'h381, 12'h382, 12'h383, 12'h384, 12'h385,
      12'hB01, 12'hB81, 12'h321, 12'h701, 12'h741: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Expected read value from the scoreboard
  function automatic logic [31:0] model_read(input logic [11:0] a);
    case (a)
      // RV32 base with only I
      12'hF00: return 32'h0000_0100;
      12'hF01: return `MIMPID;
      12'hF10: return `MHARTID;
      // All four prv fields at M
      12'h300: return 32'h0000_0DB6 | {31'b0, m_ie};
      12'h301: return `MTVEC_ADDR;
      12'h304: return {24'b0, m_mtie, 3'b0, m_msie, 3'b0};
      12'h340: return m_mscratch;
      12'h341: return m_mepc;
      12'h342: return m_mcause;
      12'h343: return m_mbadaddr;
      12'h344: return {24'b0, m_mtip, 3'b0, m_msip, 3'b0};
      12'h780: return m_mtohost;
      default: return 32'h0;
    endcase
  endfunction

  // Starts just after a falling edge with inputs set and ends on the next one
  task automatic run_cycle();
    logic [31:0] rd;
    logic [31:0] wv;
    logic        op;
    logic        bad;
    logic        exc_any;
    logic        i_soft;
    logic        i_timer;
    logic        intr;
    logic        trap;
    logic        mis;
    logic [30:0] code;
    // Outputs settled by mid low phase
    #(PERIOD/4);
    rd      = model_read(csr_addr);
    op      = swap | set | clr;
    bad     = op & ~addr_known(csr_addr);
    exc_any = mal_insn | illegal_insn | bad | breakpoint | env_call | mal_load | mal_store;
    i_soft  = m_ie & m_msie & m_msip;
    i_timer = m_ie & m_mtie & m_mtip;
    intr    = ~exc_any & (i_soft | i_timer);
    trap    = exc_any | intr;
    // Exceptions ranked before interrupts
    code = 31'd0;
    mis  = 1'b0;
    if (mal_insn) begin
      code = 31'd0;
      mis  = 1'b1;
    end else if (illegal_insn | bad) begin
      code = 31'd2;
    end else if (breakpoint) begin
      code = 31'd3;
    end else if (env_call) begin
      code = 31'd11;
    end else if (mal_load) begin
      code = 31'd4;
      mis  = 1'b1;
    end else if (mal_store) begin
      code = 31'd6;
      mis  = 1'b1;
    end else if (i_soft) begin
      code = 31'd0;
    end else begin
      code = 31'd1;
    end
    assert (rdata === rd)
      else fail_run($sformatf("ERROR %0t rdata expected %h got %h", $time, rd, rdata));
    assert (invalid_csr === bad)
      else fail_run($sformatf("ERROR %0t invalid_csr expected %b got %b",
                              $time, bad, invalid_csr));
    assert (insert_pc === (trap | mret))
      else fail_run($sformatf("ERROR %0t insert_pc expected %b got %b",
                              $time, trap | mret, insert_pc));
    if (trap | mret) begin
      assert (priv_pc === (trap ? `MTVEC_ADDR : m_mepc))
        else fail_run($sformatf("ERROR %0t priv_pc expected %h got %h", $time,
                                trap ? `MTVEC_ADDR : m_mepc, priv_pc));
    end
    // Read-modify-write value
    if (swap) begin
      wv = wdata;
    end else if (clr) begin
      wv = rd & ~wdata;
    end else begin
      wv = rd | wdata;
    end
    if (op && csr_addr == 12'h340) m_mscratch = wv;
    if (op && csr_addr == 12'h780) m_mtohost = wv;
    if (op && csr_addr == 12'h304) begin
      m_msie = wv[3];
      m_mtie = wv[7];
    end
    // Trap beats mret beats pipeline write
    if (trap) begin
      m_ie = 1'b0;
    end else if (mret) begin
      m_ie = 1'b1;
    end else if (op && csr_addr == 12'h300) begin
      m_ie = wv[0];
    end
    if (trap) begin
      m_mcause = {intr, code};
      m_mepc   = epc;
      if (mis) m_mbadaddr = badaddr;
    end
    m_msip = soft_int;
    m_mtip = timer_int;
    @(negedge CLK);
  endtask

  task automatic csr_access(input logic [11:0] addr, input int kind, input logic [31:0] data);
    csr_addr = addr;
    wdata    = data;
    swap     = (kind == OP_SWAP);
    set      = (kind == OP_SET);
    clr      = (kind == OP_CLR);
    run_cycle();
    swap = 1'b0;
    set  = 1'b0;
    clr  = 1'b0;
  endtask

  // Raise a set of sources for one cycle and read back the trap CSRs
  task automatic take_exceptions(input logic [5:0] bits);
    // Set ie first so every trap has to clear it
    csr_access(12'h300, OP_SET, 32'h1);
    mal_insn     = bits[0];
    illegal_insn = bits[1];
    breakpoint   = bits[2];
    env_call     = bits[3];
    mal_load     = bits[4];
    mal_store    = bits[5];
    epc          = $random(seed);
    badaddr      = $random(seed);
    csr_access(12'h340, OP_READ, 32'h0);
    mal_insn     = 1'b0;
    illegal_insn = 1'b0;
    breakpoint   = 1'b0;
    env_call     = 1'b0;
    mal_load     = 1'b0;
    mal_store    = 1'b0;
    csr_access(12'h342, OP_READ, 32'h0);
    csr_access(12'h341, OP_READ, 32'h0);
    csr_access(12'h343, OP_READ, 32'h0);
    csr_access(12'h300, OP_READ, 32'h0);
  endtask

  initial begin
    int i;
    int j;
    int k;
    seed         = 82897;
    zero_addrs   = '{12'h302, 12'h380, 12'h381, 12'h382, 12'h383, 12'h384, 12'h385,
                     12'hB01, 12'hB81, 12'h321, 12'h701, 12'h741, 12'h781};
    fixed_addrs  = '{12'h341, 12'h342, 12'h344, 12'h301,
                     12'hF00, 12'hF01, 12'hF10, 12'h781};
    nRST         = 1'b0;
    csr_addr     = '0;
    swap         = 1'b0;
    set          = 1'b0;
    clr          = 1'b0;
    wdata        = '0;
    mal_insn     = 1'b0;
    illegal_insn = 1'b0;
    breakpoint   = 1'b0;
    env_call     = 1'b0;
    mal_load     = 1'b0;
    mal_store    = 1'b0;
    mret         = 1'b0;
    epc          = '0;
    badaddr      = '0;
    timer_int    = 1'b0;
    soft_int     = 1'b0;
    // Reset state has only ie set
    m_ie         = 1'b1;
    m_msie       = 1'b0;
    m_mtie       = 1'b0;
    m_msip       = 1'b0;
    m_mtip       = 1'b0;
    m_mscratch   = '0;
    m_mtohost    = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_mbadaddr   = '0;
    repeat (10) @(negedge CLK);
    nRST = 1'b1;

    // Identity, mstatus and trap vector after reset
    csr_access(12'hF00, OP_READ, 32'h0);
    csr_access(12'h300, OP_READ, 32'h0);
    csr_access(12'h301, OP_READ, 32'h0);
    // Zero-read space hit with a harmless set
    for (i = 0; i < 13; i++) begin
      csr_access(zero_addrs[i], OP_SET, 32'h0);
    end
    // Unknown address traps as illegal
    epc = $random(seed);
    csr_access(12'h123, OP_SET, 32'h0);
    csr_access(12'h342, OP_READ, 32'h0);

    // Full-word scratch and host registers
    for (k = 0; k < 4; k++) begin
      csr_access(12'h340, OP_SWAP, $random(seed));
      csr_access(12'h340, OP_SET, $random(seed));
      csr_access(12'h340, OP_CLR, $random(seed));
      csr_access(12'h780, OP_SWAP, $random(seed));
      csr_access(12'h780, OP_SET, $random(seed));
      csr_access(12'h780, OP_CLR, $random(seed));
    end
    csr_access(12'h780, OP_READ, 32'h0);

    // Read-only and controller-owned registers ignore writes
    for (i = 0; i < 8; i++) begin
      csr_access(fixed_addrs[i], OP_SWAP, $random(seed));
      csr_access(fixed_addrs[i], OP_READ, 32'h0);
    end
    // Only the live mie bits stick
    csr_access(12'h304, OP_SWAP, 32'hFFFF_FFFF);
    csr_access(12'h304, OP_READ, 32'h0);
    csr_access(12'h304, OP_SWAP, 32'h0);
    // Only ie changes in mstatus
    csr_access(12'h300, OP_SWAP, 32'hFFFF_FFFE);
    csr_access(12'h300, OP_READ, 32'h0);
    csr_access(12'h300, OP_SWAP, 32'hFFFF_FFFF);
    csr_access(12'h300, OP_READ, 32'h0);

    // Single sources and then every pair
    for (i = 0; i < 6; i++) begin
      take_exceptions(6'b1 << i);
    end
    for (i = 0; i < 6; i++) begin
      for (j = i + 1; j < 6; j++) begin
        take_exceptions((6'b1 << i) | (6'b1 << j));
      end
    end

    // Timer interrupt with mtie and ie set
    csr_access(12'h304, OP_SET, 32'h0000_0080);
    csr_access(12'h300, OP_SET, 32'h1);
    timer_int = 1'b1;
    epc       = $random(seed);
    repeat (3) csr_access(12'h342, OP_READ, 32'h0);
    // Nothing taken while ie is clear
    repeat (3) csr_access(12'h300, OP_READ, 32'h0);
    // Software wins over timer
    soft_int = 1'b1;
    csr_access(12'h304, OP_SET, 32'h0000_0008);
    csr_access(12'h300, OP_SET, 32'h1);
    repeat (2) csr_access(12'h342, OP_READ, 32'h0);
    soft_int  = 1'b0;
    timer_int = 1'b0;
    csr_access(12'h304, OP_CLR, 32'h0000_0088);
    csr_access(12'h344, OP_READ, 32'h0);

    // Return to the saved PC with ie back on
    mret = 1'b1;
    csr_access(12'h341, OP_READ, 32'h0);
    mret = 1'b0;
    csr_access(12'h300, OP_READ, 32'h0);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/rv32i_types_pkg.sv
logic/machine_mode_types_pkg.sv
logic/csr_rfile.sv
logic/prv_control.sv
logic/prv_block.sv
testbench/tb_prv_block.sv
